//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_taint_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard src/*.svh)
VECTORS   := sim/taint_vectors.mem

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/taint_vectors.mem
// op a a_taint b b_taint ctrl kind exp1 exp2 (kind 0 reset, 1 op, 2 step, 3 mem write, 4/5 error)
// ctrl: CTRL bits, MEMCFG word for kind 3, error address for kinds 4/5 (a is then write data)
0 0000 0000 0000 0000 00 0 0000 0000
0 F0F0 00FF 3C3C 0000 00 1 3030 003C
0 1234 0F00 FFFF F000 00 1 1234 1F00
1 F0F0 00FF 3C3C 0000 00 1 FCFC 00C3
1 00FF 0000 0000 FFFF 00 1 00FF FF00
2 1234 000F 1238 0000 00 1 0000 0001
2 1234 0000 1234 0000 00 1 0001 0000
2 1234 000F 5234 0000 00 1 0000 0000
3 00F3 000F 0014 0000 00 1 0F30 00F0
3 00F3 000F 0004 0001 00 1 0F30 FFFF
4 F300 F000 0008 0000 00 1 00F3 00F0
4 F300 0000 0008 8000 00 1 00F3 FFFF
6 1111 0100 2222 0000 00 1 3333 FFFF
6 FFFF 0000 0002 0000 00 1 0001 0000
7 AAAA 0000 5555 0010 00 1 FFFF FFFF
7 AAAA 0000 0F0F 0000 00 1 A5A5 0000
5 1234 00F0 ABCD 0F00 00 1 1234 00F0
5 1234 00F0 ABCD 0F00 08 1 ABCD 0F00
5 1234 00F0 ABCD 0F00 18 1 ABCD BFF9
5 1234 00F0 ABCD 0F00 10 1 1234 B9F9
0 FF00 0FF0 F0F0 0000 20 2 F000 00F0
7 0F0F 0000 00FF 0000 60 2 0FF0 FFF0
7 1234 0001 0000 0000 00 2 0FF0 FFF0
0 0FF1 0000 FFFF 0000 40 2 0FF0 FFF1
1 0000 0000 0000 0000 20 2 0000 0000
7 0000 00FF 0000 0000 00FF0003 3 00FF 0001
0 FFFF 0000 F0F0 FF00 F0000005 3 F000 0002
0 0000 0000 0000 0000 00000017 3 FFFF 0003
7 0000 0000 0000 0000 FFFF0005 3 0000 0002
3 0001 0001 0000 0000 FFFF0003 3 0001 0002
0 1234 0000 0000 0000 18 4 0001 0001
0 FFFF 0000 0000 0000 40 4 0001 0001
0 0000 0000 0000 0000 3C 5 0001 0001

//--- sim/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic pos_clk
);

    // free running, 10 ns period
    initial begin
        pos_clk = 1'b0;
        forever begin
            #5;
            pos_clk = ~pos_clk;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_taint_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "taint_params.svh"

module tb_taint_top;
    import taint_pkg::*;

    localparam int NUM_VEC     = 33;
    localparam int VEC_WORDS   = 9;
    localparam int RESET_CYC   = 4;
    // at most nine 3-cycle transfers per vector plus slack
    localparam int CYC_PER_VEC = 32;
    localparam int WATCHDOG_NS = (NUM_VEC * CYC_PER_VEC + RESET_CYC) * 10 + 200;

    // writable registers A through MEMCFG
    localparam int NUM_RW = 6;

    // column positions in one vector line
    localparam int F_OP   = 0;
    localparam int F_A    = 1;
    localparam int F_AT   = 2;
    localparam int F_B    = 3;
    localparam int F_BT   = 4;
    localparam int F_CTRL = 5;
    localparam int F_KIND = 6;
    localparam int F_EXP1 = 7;
    localparam int F_EXP2 = 8;

    // vector kinds
    localparam int K_RESET  = 0;
    localparam int K_OP     = 1;
    localparam int K_STEP   = 2;
    localparam int K_MEMW   = 3;
    localparam int K_ERR_WR = 4;
    localparam int K_ERR_RD = 5;

    logic        pos_clk;
    logic        pos_arst;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
    // last value written to each writable register, by word offset
    apb_data_t   reg_model [NUM_RW];
    int          pass_cnt;
    int          fail_cnt;
    int          test_errs;
    string       test_name;

    tb_clock_gen u_clock_gen (
        .pos_clk(pos_clk)
    );

    taint_top u_taint_top (
        .pos_clk(pos_clk), .pos_arst(pos_arst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    // setup cycle, access cycle, then back to idle
    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge pos_clk);
        #1;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge pos_clk);
        #1;
        penable = 1'b1;
        while ((pready !== 1'b1) && (waits < 16)) begin
            @(posedge pos_clk);
            #1;
            waits++;
        end
        if (pready !== 1'b1) begin
            $display("ERROR: %s pready never rose at address %02h", test_name, addr);
            test_errs++;
        end
        // response was registered at the end of setup so it is stable here
        rdata = prdata;
        err   = pslverr;
        @(posedge pos_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // bits of a writable register that the register map defines
    function automatic apb_data_t written_bits(input apb_addr_t addr, input apb_data_t data);
        case (addr)
            `TAINT_ADDR_CTRL:   return data & 32'h0000_007F;
            `TAINT_ADDR_MEMCFG: return data & 32'hFFFF_001F;
            default:            return data & 32'h0000_FFFF;
        endcase
    endfunction

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused_rd;
        logic      err;
        apb_xfer(addr, 1'b1, data, unused_rd, err);
        if (err !== 1'b0) begin
            $display("ERROR: %s write to %02h got a slave error", test_name, addr);
            test_errs++;
        end
        if (addr <= `TAINT_ADDR_MEMCFG) begin
            reg_model[addr[4:2]] = written_bits(addr, data);
        end
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_xfer(addr, 1'b0, '0, data, err);
        if (err !== 1'b0) begin
            $display("ERROR: %s read of %02h got a slave error", test_name, addr);
            test_errs++;
        end
    endtask

    task automatic check_read(input apb_addr_t addr, input apb_data_t exp, input string what);
        apb_data_t got;
        read_reg(addr, got);
        if (got !== exp) begin
            $display("MISMATCH %s %s expected %08h actual %08h", test_name, what, exp, got);
            test_errs++;
        end
    endtask

    function automatic string kind_label(input logic [31:0] kind, input logic [31:0] op);
        op_code_t oc;
        oc = op_code_t'(op[2:0]);
        case (kind)
            K_RESET:  return "reset";
            K_OP:     return oc.name();
            K_STEP:   return "step";
            K_MEMW:   return "mem_write";
            K_ERR_WR: return "err_write";
            K_ERR_RD: return "err_read";
            default:  return "unknown";
        endcase
    endfunction

    task automatic run_vector(input int v);
        logic [31:0] f [VEC_WORDS];
        apb_data_t   rd;
        logic        err;
        for (int i = 0; i < VEC_WORDS; i++) begin
            f[i] = vec_mem[v*VEC_WORDS + i];
        end
        test_errs = 0;
        test_name = $sformatf("vec%0d_%s", v, kind_label(f[F_KIND], f[F_OP]));

        // operand setup for the datapath kinds
        if ((f[F_KIND] == K_OP) || (f[F_KIND] == K_STEP) || (f[F_KIND] == K_MEMW)) begin
            write_reg(`TAINT_ADDR_A, f[F_A]);
            write_reg(`TAINT_ADDR_A_TAINT, f[F_AT]);
            write_reg(`TAINT_ADDR_B, f[F_B]);
            write_reg(`TAINT_ADDR_B_TAINT, f[F_BT]);
            if (f[F_KIND] == K_MEMW) begin
                write_reg(`TAINT_ADDR_CTRL, f[F_OP]);
                write_reg(`TAINT_ADDR_MEMCFG, f[F_CTRL]);
            end else begin
                write_reg(`TAINT_ADDR_CTRL, f[F_OP] | f[F_CTRL]);
            end
        end

        case (f[F_KIND])
            K_RESET: begin
                check_read(`TAINT_ADDR_RESULT_TAINT, f[F_EXP1], "RESULT_TAINT");
                check_read(`TAINT_ADDR_HELD, f[F_EXP1], "HELD");
                check_read(`TAINT_ADDR_HELD_TAINT, f[F_EXP1], "HELD_TAINT");
                check_read(`TAINT_ADDR_MEM_RD, f[F_EXP1], "MEM_RD");
                check_read(`TAINT_ADDR_COUNT, f[F_EXP1], "COUNT");
            end
            K_OP: begin
                check_read(`TAINT_ADDR_RESULT, f[F_EXP1], "RESULT");
                check_read(`TAINT_ADDR_RESULT_TAINT, f[F_EXP2], "RESULT_TAINT");
            end
            K_STEP: begin
                write_reg(`TAINT_ADDR_STEP, '0);
                check_read(`TAINT_ADDR_HELD, f[F_EXP1], "HELD");
                check_read(`TAINT_ADDR_HELD_TAINT, f[F_EXP2], "HELD_TAINT");
            end
            K_MEMW: begin
                write_reg(`TAINT_ADDR_MEM_WRITE, '0);
                check_read(`TAINT_ADDR_MEM_RD, f[F_EXP1], "MEM_RD");
                check_read(`TAINT_ADDR_COUNT, f[F_EXP2], "COUNT");
            end
            K_ERR_WR, K_ERR_RD: begin
                apb_xfer(f[F_CTRL][7:0], f[F_KIND] == K_ERR_WR, f[F_A], rd, err);
                if (err !== 1'b1) begin
                    $display("ERROR: %s access to %02h gave no slave error",
                             test_name, f[F_CTRL][7:0]);
                    test_errs++;
                end
                // nothing else may have moved
                check_read(`TAINT_ADDR_A, f[F_EXP1], "A");
                check_read(`TAINT_ADDR_RESULT, f[F_EXP2], "RESULT");
                for (int r = 1; r < NUM_RW; r++) begin
                    check_read(apb_addr_t'(r * 4), reg_model[r],
                               $sformatf("reg %02h", r * 4));
                end
            end
            default: begin
                $display("ERROR: %s has an unknown vector kind %0d", test_name, f[F_KIND]);
                test_errs++;
            end
        endcase

        if (test_errs == 0) begin
            $display("ok   %s", test_name);
            pass_cnt++;
        end else begin
            $display("bad  %s with %0d errors", test_name, test_errs);
            fail_cnt++;
        end
    endtask

    initial begin
        pos_arst  = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_errs = 0;
        test_name = "";
        for (int i = 0; i < NUM_RW; i++) begin
            reg_model[i] = '0;
        end
        $readmemh("sim/taint_vectors.mem", vec_mem);
        repeat (RESET_CYC) @(posedge pos_clk);
        #1;
        pos_arst = 1'b0;
        for (int v = 0; v < NUM_VEC; v++) begin
            run_vector(v);
        end
        $display("tests %0d passed %0d failed %0d", NUM_VEC, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/taint_pkg.sv
src/taint_apb_regs.sv
src/taint_op_unit.sv
src/taint_hold_reg.sv
src/taint_shadow_mem.sv
src/taint_apb_readback.sv
src/taint_top.sv
sim/tb_clock_gen.sv
sim/tb_taint_top.sv

//--- src/taint_apb_readback.sv
`timescale 1ns/100ps
`default_nettype none

module taint_apb_readback (
    input  wire logic                   pos_clk,
    input  wire logic                   pos_arst,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire taint_pkg::rd_sel_t     rd_sel,
    input  wire logic                   addr_err,
    input  wire taint_pkg::data_t       a_val,
    input  wire taint_pkg::taint_t      a_taint,
    input  wire taint_pkg::data_t       b_val,
    input  wire taint_pkg::taint_t      b_taint,
    input  wire taint_pkg::op_code_t    op,
    input  wire logic                   sel,
    input  wire logic                   sel_taint,
    input  wire logic                   en,
    input  wire logic                   en_taint,
    input  wire taint_pkg::mem_addr_t   mem_addr,
    input  wire logic                   mem_addr_taint,
    input  wire taint_pkg::taint_t      wr_mask,
    input  wire taint_pkg::data_t       res_val,
    input  wire taint_pkg::taint_t      res_taint,
    input  wire taint_pkg::data_t       held_val,
    input  wire taint_pkg::taint_t      held_taint,
    input  wire taint_pkg::taint_t      mem_rd_taint,
    input  wire taint_pkg::taint_cnt_t  taint_count,
    output taint_pkg::apb_data_t        prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import taint_pkg::*;

    apb_data_t rd_word;
    logic      setup_phase;

    assign setup_phase = psel & ~penable;

    // zero wait states
    assign pready = 1'b1;

    always_comb begin
        case (rd_sel)
            RD_A:        rd_word = apb_data_t'(a_val);
            RD_AT:       rd_word = apb_data_t'(a_taint);
            RD_B:        rd_word = apb_data_t'(b_val);
            RD_BT:       rd_word = apb_data_t'(b_taint);
            RD_CTRL:     rd_word = apb_data_t'({en_taint, en, sel_taint, sel, op});
            RD_MEMCFG:   rd_word = (apb_data_t'(wr_mask) << 16)
                                 | apb_data_t'({mem_addr_taint, mem_addr});
            RD_RESULT:   rd_word = apb_data_t'(res_val);
            RD_RESULT_T: rd_word = apb_data_t'(res_taint);
            RD_HELD:     rd_word = apb_data_t'(held_val);
            RD_HELD_T:   rd_word = apb_data_t'(held_taint);
            RD_MEM_RD:   rd_word = apb_data_t'(mem_rd_taint);
            RD_COUNT:    rd_word = apb_data_t'(taint_count);
            default:     rd_word = '0;
        endcase
    end

    // sample in setup so the access cycle sees a stable response
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup_phase) begin
            prdata  <= rd_word;
            pslverr <= addr_err;
        end else if (psel & penable) begin
            pslverr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/taint_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "taint_params.svh"

module taint_apb_regs (
    input  wire logic                 pos_clk,
    input  wire logic                 pos_arst,
    input  wire taint_pkg::apb_addr_t paddr,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire taint_pkg::apb_data_t pwdata,
    output taint_pkg::data_t          a_val,
    output taint_pkg::taint_t         a_taint,
    output taint_pkg::data_t          b_val,
    output taint_pkg::taint_t         b_taint,
    output taint_pkg::op_code_t       op,
    output logic                      sel,
    output logic                      sel_taint,
    output logic                      en,
    output logic                      en_taint,
    output taint_pkg::mem_addr_t      mem_addr,
    output logic                      mem_addr_taint,
    output taint_pkg::taint_t         wr_mask,
    output logic                      step_pulse,
    output logic                      mem_wr_pulse,
    output taint_pkg::rd_sel_t        rd_sel,
    output logic                      addr_err
);
    import taint_pkg::*;

    rd_sel_t dec_sel;
    logic    mapped;
    logic    ro_hit;
    logic    wr_access;

    // address decode, shared by reads and writes
    always_comb begin
        dec_sel = RD_NONE;
        mapped  = 1'b1;
        case (paddr)
            `TAINT_ADDR_A:            dec_sel = RD_A;
            `TAINT_ADDR_A_TAINT:      dec_sel = RD_AT;
            `TAINT_ADDR_B:            dec_sel = RD_B;
            `TAINT_ADDR_B_TAINT:      dec_sel = RD_BT;
            `TAINT_ADDR_CTRL:         dec_sel = RD_CTRL;
            `TAINT_ADDR_MEMCFG:       dec_sel = RD_MEMCFG;
            `TAINT_ADDR_RESULT:       dec_sel = RD_RESULT;
            `TAINT_ADDR_RESULT_TAINT: dec_sel = RD_RESULT_T;
            `TAINT_ADDR_HELD:         dec_sel = RD_HELD;
            `TAINT_ADDR_HELD_TAINT:   dec_sel = RD_HELD_T;
            `TAINT_ADDR_MEM_RD:       dec_sel = RD_MEM_RD;
            `TAINT_ADDR_COUNT:        dec_sel = RD_COUNT;
            // write-only commands read back as zero
            `TAINT_ADDR_STEP,
            `TAINT_ADDR_MEM_WRITE:    dec_sel = RD_NONE;
            default:                  mapped  = 1'b0;
        endcase
    end

    assign ro_hit    = dec_sel inside {[RD_RESULT:RD_COUNT]};
    assign addr_err  = ~mapped | (pwrite & ro_hit);
    assign rd_sel    = pwrite ? RD_NONE : dec_sel;
    assign wr_access = psel & penable & pwrite & ~addr_err;

    // command strobes last exactly the access cycle
    assign step_pulse   = wr_access & (paddr == `TAINT_ADDR_STEP);
    assign mem_wr_pulse = wr_access & (paddr == `TAINT_ADDR_MEM_WRITE);

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            a_val          <= '0;
            a_taint        <= '0;
            b_val          <= '0;
            b_taint        <= '0;
            op             <= OP_AND;
            sel            <= 1'b0;
            sel_taint      <= 1'b0;
            en             <= 1'b0;
            en_taint       <= 1'b0;
            mem_addr       <= '0;
            mem_addr_taint <= 1'b0;
            wr_mask        <= '0;
        end else if (wr_access) begin
            case (paddr)
                `TAINT_ADDR_A:       a_val   <= pwdata[`TAINT_DATA_W-1:0];
                `TAINT_ADDR_A_TAINT: a_taint <= pwdata[`TAINT_DATA_W-1:0];
                `TAINT_ADDR_B:       b_val   <= pwdata[`TAINT_DATA_W-1:0];
                `TAINT_ADDR_B_TAINT: b_taint <= pwdata[`TAINT_DATA_W-1:0];
                `TAINT_ADDR_CTRL: begin
                    op        <= op_code_t'(pwdata[2:0]);
                    sel       <= pwdata[3];
                    sel_taint <= pwdata[4];
                    en        <= pwdata[5];
                    en_taint  <= pwdata[6];
                end
                `TAINT_ADDR_MEMCFG: begin
                    mem_addr       <= pwdata[`TAINT_MEM_AW-1:0];
                    mem_addr_taint <= pwdata[4];
                    wr_mask        <= pwdata[31:16];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/taint_hold_reg.sv
`timescale 1ns/100ps
`default_nettype none

module taint_hold_reg (
    input  wire logic               pos_clk,
    input  wire logic               pos_arst,
    input  wire logic               step_pulse,
    input  wire logic               en,
    input  wire logic               en_taint,
    input  wire taint_pkg::data_t   d_val,
    input  wire taint_pkg::taint_t  d_taint,
    output taint_pkg::data_t        q_val,
    output taint_pkg::taint_t       q_taint
);
    import taint_pkg::*;

    // bits that would change if the enable went the other way
    taint_t en_leak;

    assign en_leak = en_taint ? taint_t'(d_val ^ q_val) : '0;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            q_val   <= '0;
            q_taint <= '0;
        end else if (step_pulse) begin
            if (en) begin
                q_val   <= d_val;
                q_taint <= d_taint | en_leak;
            end else begin
                // value holds, taint can only grow
                q_taint <= q_taint | en_leak;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/taint_op_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "taint_params.svh"

module taint_op_unit (
    input  wire taint_pkg::data_t     a_val,
    input  wire taint_pkg::taint_t    a_taint,
    input  wire taint_pkg::data_t     b_val,
    input  wire taint_pkg::taint_t    b_taint,
    input  wire taint_pkg::op_code_t  op,
    input  wire logic                 sel,
    input  wire logic                 sel_taint,
    output taint_pkg::data_t          res_val,
    output taint_pkg::taint_t         res_taint
);
    import taint_pkg::*;

    localparam int SHAMT_W = $clog2(`TAINT_DATA_W);

    logic [SHAMT_W-1:0] shamt;
    logic               any_taint;
    logic               b_tainted;
    taint_t             eq_mask;
    taint_t             mux_diff;

    assign shamt     = b_val[SHAMT_W-1:0];
    assign any_taint = |{a_taint, b_taint};
    assign b_tainted = |b_taint;

    // tainted bits of either side are left out of the compare
    assign eq_mask = ~(a_taint | b_taint);

    // a tainted select leaks every bit where the inputs differ
    assign mux_diff = sel_taint ? taint_t'(a_val ^ b_val) : '0;

    always_comb begin
        res_val   = '0;
        res_taint = '0;
        case (op)
            OP_AND: begin
                res_val   = a_val & b_val;
                res_taint = (a_taint & b_val) | (b_taint & a_val) | (a_taint & b_taint);
            end
            OP_OR: begin
                res_val   = a_val | b_val;
                res_taint = (a_taint & ~b_val) | (b_taint & ~a_val) | (a_taint & b_taint);
            end
            OP_EQ: begin
                res_val   = data_t'(a_val == b_val);
                res_taint = taint_t'(((a_val & eq_mask) == (b_val & eq_mask)) && any_taint);
            end
            OP_SHL: begin
                res_val   = a_val << shamt;
                res_taint = b_tainted ? '1 : (a_taint << shamt);
            end
            OP_SHR: begin
                res_val   = a_val >> shamt;
                res_taint = b_tainted ? '1 : (a_taint >> shamt);
            end
            OP_MUX: begin
                res_val   = sel ? b_val : a_val;
                res_taint = (sel ? b_taint : a_taint) | mux_diff;
            end
            // add and xor fall back to the coarse rule
            OP_ADD: begin
                res_val   = a_val + b_val;
                res_taint = any_taint ? '1 : '0;
            end
            OP_XOR: begin
                res_val   = a_val ^ b_val;
                res_taint = any_taint ? '1 : '0;
            end
            default: begin
                res_val   = '0;
                res_taint = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/taint_params.svh
`ifndef TAINT_PARAMS_SVH
`define TAINT_PARAMS_SVH

// bus and datapath widths
`define TAINT_APB_AW     8
`define TAINT_APB_DW     32
`define TAINT_DATA_W     16
`define TAINT_MEM_DEPTH  16
`define TAINT_MEM_AW     4
`define TAINT_CNT_W      5

// register map, byte offsets
`define TAINT_ADDR_A             8'h00
`define TAINT_ADDR_A_TAINT       8'h04
`define TAINT_ADDR_B             8'h08
`define TAINT_ADDR_B_TAINT       8'h0C
`define TAINT_ADDR_CTRL          8'h10
`define TAINT_ADDR_MEMCFG        8'h14
`define TAINT_ADDR_RESULT        8'h18
`define TAINT_ADDR_RESULT_TAINT  8'h1C
`define TAINT_ADDR_HELD          8'h20
`define TAINT_ADDR_HELD_TAINT    8'h24
`define TAINT_ADDR_MEM_RD        8'h28
`define TAINT_ADDR_COUNT         8'h2C
`define TAINT_ADDR_STEP          8'h30
`define TAINT_ADDR_MEM_WRITE     8'h34

`endif

//--- src/taint_pkg.sv
`default_nettype none

`include "taint_params.svh"

package taint_pkg;

    typedef logic [`TAINT_APB_AW-1:0]  apb_addr_t;
    typedef logic [`TAINT_APB_DW-1:0]  apb_data_t;
    typedef logic [`TAINT_DATA_W-1:0]  data_t;
    // one bit per data bit, set when it may depend on a secret
    typedef logic [`TAINT_DATA_W-1:0]  taint_t;
    typedef logic [`TAINT_MEM_AW-1:0]  mem_addr_t;
    typedef logic [`TAINT_CNT_W-1:0]   taint_cnt_t;

    typedef enum logic [2:0] {
        OP_AND = 3'd0,
        OP_OR  = 3'd1,
        OP_EQ  = 3'd2,
        OP_SHL = 3'd3,
        OP_SHR = 3'd4,
        OP_MUX = 3'd5,
        OP_ADD = 3'd6,
        OP_XOR = 3'd7
    } op_code_t;

    // read-only sources sit between RD_RESULT and RD_COUNT
    typedef enum logic [3:0] {
        RD_A, RD_AT, RD_B, RD_BT, RD_CTRL, RD_MEMCFG,
        RD_RESULT, RD_RESULT_T, RD_HELD, RD_HELD_T, RD_MEM_RD, RD_COUNT,
        RD_NONE
    } rd_sel_t;

endpackage

`default_nettype wire

//--- src/taint_shadow_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "taint_params.svh"

module taint_shadow_mem (
    input  wire logic                 pos_clk,
    input  wire logic                 pos_arst,
    input  wire logic                 mem_wr_pulse,
    input  wire taint_pkg::mem_addr_t mem_addr,
    input  wire logic                 mem_addr_taint,
    input  wire taint_pkg::taint_t    wr_mask,
    input  wire taint_pkg::taint_t    wr_taint,
    output taint_pkg::taint_t         rd_taint,
    output taint_pkg::taint_cnt_t     taint_count
);
    import taint_pkg::*;

    taint_t cells [`TAINT_MEM_DEPTH];
    taint_t cell_old;
    taint_t cell_new;

    assign cell_old = cells[mem_addr];

    // a tainted address may have hit any cell
    assign cell_new = (wr_taint & wr_mask) | {`TAINT_DATA_W{mem_addr_taint}};

    assign rd_taint = cells[mem_addr] | {`TAINT_DATA_W{mem_addr_taint}};

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < `TAINT_MEM_DEPTH; i++) begin
                cells[i] <= '0;
            end
        end else if (mem_wr_pulse) begin
            cells[mem_addr] <= cell_new;
        end
    end

    // count of cells holding any taint
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            taint_count <= '0;
        end else if (mem_wr_pulse) begin
            if ((cell_old == '0) && (cell_new != '0)) begin
                taint_count <= taint_count + 1'b1;
            end else if ((cell_old != '0) && (cell_new == '0)) begin
                taint_count <= taint_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/taint_top.sv
`timescale 1ns/100ps
`default_nettype none

module taint_top (
    input  wire logic                 pos_clk,
    input  wire logic                 pos_arst,
    input  wire taint_pkg::apb_addr_t paddr,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire taint_pkg::apb_data_t pwdata,
    output taint_pkg::apb_data_t      prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import taint_pkg::*;

    // register file outputs
    data_t      a_val;
    taint_t     a_taint;
    data_t      b_val;
    taint_t     b_taint;
    op_code_t   op;
    logic       sel;
    logic       sel_taint;
    logic       en;
    logic       en_taint;
    mem_addr_t  mem_addr;
    logic       mem_addr_taint;
    taint_t     wr_mask;
    logic       step_pulse;
    logic       mem_wr_pulse;
    rd_sel_t    rd_sel;
    logic       addr_err;

    // datapath results
    data_t      res_val;
    taint_t     res_taint;
    data_t      held_val;
    taint_t     held_taint;
    taint_t     mem_rd_taint;
    taint_cnt_t taint_count;

    taint_apb_regs u_regs (
        .pos_clk(pos_clk), .pos_arst(pos_arst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .a_val(a_val), .a_taint(a_taint), .b_val(b_val), .b_taint(b_taint),
        .op(op), .sel(sel), .sel_taint(sel_taint), .en(en), .en_taint(en_taint),
        .mem_addr(mem_addr), .mem_addr_taint(mem_addr_taint), .wr_mask(wr_mask),
        .step_pulse(step_pulse), .mem_wr_pulse(mem_wr_pulse),
        .rd_sel(rd_sel), .addr_err(addr_err)
    );

    taint_op_unit u_op_unit (
        .a_val(a_val), .a_taint(a_taint), .b_val(b_val), .b_taint(b_taint),
        .op(op), .sel(sel), .sel_taint(sel_taint),
        .res_val(res_val), .res_taint(res_taint)
    );

    taint_hold_reg u_hold_reg (
        .pos_clk(pos_clk), .pos_arst(pos_arst), .step_pulse(step_pulse),
        .en(en), .en_taint(en_taint), .d_val(res_val), .d_taint(res_taint),
        .q_val(held_val), .q_taint(held_taint)
    );

    taint_shadow_mem u_shadow_mem (
        .pos_clk(pos_clk), .pos_arst(pos_arst), .mem_wr_pulse(mem_wr_pulse),
        .mem_addr(mem_addr), .mem_addr_taint(mem_addr_taint),
        .wr_mask(wr_mask), .wr_taint(res_taint),
        .rd_taint(mem_rd_taint), .taint_count(taint_count)
    );

    taint_apb_readback u_readback (
        .pos_clk(pos_clk), .pos_arst(pos_arst), .psel(psel), .penable(penable),
        .rd_sel(rd_sel), .addr_err(addr_err),
        .a_val(a_val), .a_taint(a_taint), .b_val(b_val), .b_taint(b_taint),
        .op(op), .sel(sel), .sel_taint(sel_taint), .en(en), .en_taint(en_taint),
        .mem_addr(mem_addr), .mem_addr_taint(mem_addr_taint), .wr_mask(wr_mask),
        .res_val(res_val), .res_taint(res_taint),
        .held_val(held_val), .held_taint(held_taint),
        .mem_rd_taint(mem_rd_taint), .taint_count(taint_count),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

endmodule

`default_nettype wire
